//--- Bender.yml
package:
  name: mandelbrot_framebuffer

sources:
  - include_dirs:
      - include
    files:
      - source/render_pkg.sv
      - source/bus_pkg.sv
      - source/view_decode.sv
      - source/mandelbrot_iter.sv
      - source/pixel_writer.sv
      - source/framebuffer_mem.sv
      - source/mandelbrot_framebuffer.sv

  - target: test
    files:
      - dv/mandelbrot_framebuffer_assert.sv
      - dv/tb_mandelbrot_framebuffer.sv

//--- dv/mandelbrot_framebuffer_assert.sv
module mandelbrot_framebuffer_assert (
    input logic                          clk,
    input logic                          rst,
    input logic                          start,
    input logic                          busy,
    input logic                          frame_done,
    input logic [render_pkg::zoom_w-1:0] zoom_level,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic [bus_pkg::wb_aw-1:0]     wb_adr,
    input logic [bus_pkg::wb_dw-1:0]     wb_dat_w,
    input logic                          wb_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;

    task automatic flag_error(string msg);
        $error("%s", msg);
        error_count++;
    endtask

    // ------------------------------------------------------------
    // Wishbone classic write
    // ------------------------------------------------------------

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else flag_error("wb_stb is high while wb_cyc is low");

    // Request held until the slave acks
    req_held: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w))
        else flag_error("Request dropped or changed before wb_ack");

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
        else flag_error("wb_ack without a request in the cycle before");

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else flag_error("wb_ack stayed high for more than one cycle");

    // ------------------------------------------------------------
    // Frame control
    // ------------------------------------------------------------

    done_single: assert property (@(posedge clk) disable iff (rst) frame_done |=> !frame_done)
        else flag_error("frame_done stayed high for more than one cycle");

    done_with_busy_fall: assert property (@(posedge clk) disable iff (rst)
        frame_done == $fell(busy))
        else flag_error("frame_done and the fall of busy are not in the same cycle");

    start_raises_busy: assert property (@(posedge clk) disable iff (rst)
        start && !busy |=> busy)
        else flag_error("busy did not rise in the cycle after start");

    reset_clears: assert property (@(posedge clk)
        rst |=> !busy && !frame_done && !wb_cyc && zoom_level == '0)
        else flag_error("Outputs not cleared in the cycle after reset");

    // Saturating level, so it never wraps between 0 and zoom_max
    zoom_step: assert property (@(posedge clk) disable iff (rst)
        $stable(zoom_level) ||
        int'(zoom_level) == int'($past(zoom_level)) + 1 ||
        int'(zoom_level) == int'($past(zoom_level)) - 1)
        else flag_error("zoom_level wrapped or jumped by more than one level");

    zoom_frozen: assert property (@(posedge clk) disable iff (rst)
        busy |=> $stable(zoom_level))
        else flag_error("zoom_level changed during a frame");

endmodule

bind mandelbrot_framebuffer mandelbrot_framebuffer_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .busy       (busy),
    .frame_done (frame_done),
    .zoom_level (zoom_level),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack)
);

//--- dv/tb_mandelbrot_framebuffer.sv
module tb_mandelbrot_framebuffer;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 20;
    localparam int n_frames   = 5;
    localparam int max_limit  = 64;
    localparam int n_pixels   = render_pkg::screen_w * render_pkg::screen_h;
    localparam longint watchdog_ns =
        2 * longint'(n_frames) * n_pixels * (max_limit + 4) * clk_period;

    logic                           clk;
    logic                           rst;
    logic                           start;
    logic                           zoom_in;
    logic                           zoom_out;
    logic                           start_ovd;
    logic [render_pkg::coord_w-1:0] start_real_ovd;
    logic [render_pkg::coord_w-1:0] start_imag_ovd;
    logic [render_pkg::iter_w-1:0]  max_iteration;
    logic [bus_pkg::wb_aw-1:0]      rd_addr;
    logic                           busy;
    logic                           frame_done;
    logic [render_pkg::zoom_w-1:0]  zoom_level;
    logic [bus_pkg::wb_dw-1:0]      rd_data;

    logic [31:0] rand_state;
    int          exp_zoom;
    int          org_re;
    int          org_im;
    int          frame_step;
    int          exp_limit;
    bit          frame_active;
    logic [31:0] corner_re;
    logic [31:0] corner_im;

    mandelbrot_framebuffer mandelbrot_framebuffer_inst (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .zoom_in        (zoom_in),
        .zoom_out       (zoom_out),
        .start_ovd      (start_ovd),
        .start_real_ovd (start_real_ovd),
        .start_imag_ovd (start_imag_ovd),
        .max_iteration  (max_iteration),
        .rd_addr        (rd_addr),
        .busy           (busy),
        .frame_done     (frame_done),
        .zoom_level     (zoom_level),
        .rd_data        (rd_data)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // Q4.28 value in [-2.0, 2.0)
    function automatic logic [31:0] random_corner();
        logic [31:0] r;
        r = lcg_next();
        return (r >> 2) - 32'h2000_0000;
    endfunction

    function automatic int escape_count(int cr, int ci, int limit);
        int                zr;
        int                zi;
        int                count;
        bit                done;
        longint            rr;
        longint            ii;
        longint            ri;
        longint unsigned   mag;
        zr    = 0;
        zi    = 0;
        count = 0;
        done  = 1'b0;
        while (!done) begin
            rr  = longint'(zr) * longint'(zr);
            ii  = longint'(zi) * longint'(zi);
            ri  = longint'(zr) * longint'(zi);
            mag = $unsigned(rr) + $unsigned(ii);
            if (mag > (64'd4 << (2 * render_pkg::frac_bits)) || count == limit) begin
                done = 1'b1;
            end else begin
                zr = int'((rr >>> render_pkg::frac_bits) - (ii >>> render_pkg::frac_bits)) + cr;
                zi = int'((ri >>> render_pkg::frac_bits) <<< 1) + ci;
                count++;
            end
        end
        return count;
    endfunction

    function automatic int pixel_color(int count, int limit);
        int color;
        if (count == limit) begin
            color = 8'h00;
        end else if (count[7:0] == 8'h00) begin
            color = 8'h01;
        end else begin
            color = count[7:0];
        end
        return color;
    endfunction

    // ------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------

    task automatic check_value(string what, int expected, int actual);
        if (expected != actual) begin
            $display("[FAIL] %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic pulse_zoom(bit inward);
        @(negedge clk);
        zoom_in  = inward;
        zoom_out = !inward;
        // Pulses while busy are dropped
        if (!frame_active) begin
            if (inward && exp_zoom < render_pkg::zoom_max) begin
                exp_zoom++;
            end else if (!inward && exp_zoom > 0) begin
                exp_zoom--;
            end
        end
        @(negedge clk);
        zoom_in  = 1'b0;
        zoom_out = 1'b0;
        check_value("zoom_level", exp_zoom, zoom_level);
    endtask

    task automatic begin_frame(bit ovd, logic [31:0] re, logic [31:0] im, int limit);
        frame_step = render_pkg::base_step >> exp_zoom;
        exp_limit  = limit;
        if (ovd) begin
            org_re = re;
            org_im = im;
        end else begin
            org_re = int'(render_pkg::center_re) - frame_step * (render_pkg::screen_w / 2);
            org_im = int'(render_pkg::center_im) - frame_step * (render_pkg::screen_h / 2);
        end
        @(negedge clk);
        max_iteration  = limit;
        start_ovd      = ovd;
        start_real_ovd = re;
        start_imag_ovd = im;
        start          = 1'b1;
        frame_active   = 1'b1;
        @(negedge clk);
        start     = 1'b0;
        start_ovd = 1'b0;
    endtask

    // Waits for frame_done, then reads back every pixel
    task automatic finish_frame();
        int addr;
        int cr;
        int ci;
        do @(negedge clk); while (!frame_done);
        frame_active = 1'b0;
        for (int y = 0; y < render_pkg::screen_h; y++) begin
            for (int x = 0; x < render_pkg::screen_w; x++) begin
                addr    = y * render_pkg::screen_w + x;
                cr      = org_re + x * frame_step;
                ci      = org_im + y * frame_step;
                rd_addr = addr;
                @(negedge clk);
                check_value($sformatf("pixel at address %0d", addr),
                            pixel_color(escape_count(cr, ci, exp_limit), exp_limit), rd_data);
            end
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    // Bound assertion failures end the run at once
    initial begin
        wait (mandelbrot_framebuffer_inst.u_assert.error_count != 0);
        $display("Verification failed");
        $fatal(1, "A bus or timing assertion on the DUT failed");
    end

    initial begin
        rand_state     = 32'h64b3;
        rst            = 1'b1;
        start          = 1'b0;
        zoom_in        = 1'b0;
        zoom_out       = 1'b0;
        start_ovd      = 1'b0;
        start_real_ovd = '0;
        start_imag_ovd = '0;
        max_iteration  = 16'd32;
        rd_addr        = '0;
        exp_zoom       = 0;
        frame_active   = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Default window at zoom level 0
        begin_frame(1'b0, '0, '0, 32);
        finish_frame();

        // Saturation at both ends, then level 3
        repeat (render_pkg::zoom_max + 2) pulse_zoom(1'b1);
        repeat (render_pkg::zoom_max + 2) pulse_zoom(1'b0);
        repeat (3) pulse_zoom(1'b1);
        begin_frame(1'b0, '0, '0, 32);
        pulse_zoom(1'b1);
        pulse_zoom(1'b0);
        finish_frame();

        // Override corner ignores the zoom level
        corner_re = random_corner();
        corner_im = random_corner();
        begin_frame(1'b1, corner_re, corner_im, 32);
        finish_frame();

        // Iteration limits
        begin_frame(1'b0, '0, '0, 1);
        finish_frame();
        corner_re = random_corner();
        corner_im = random_corner();
        begin_frame(1'b1, corner_re, corner_im, 2 + int'(lcg_next() >> 16) % (max_limit - 1));
        finish_frame();

        if (mandelbrot_framebuffer_inst.u_assert.error_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "Bus or timing assertions failed");
        end
    end

endmodule

//--- include/color.svh
`ifndef COLOR_SVH
`define COLOR_SVH

// RGB332 colour fields
`define R_SIZE 3
`define G_SIZE 3
`define B_SIZE 2

// Width of a packed colour word
`define COLOR_W (`R_SIZE + `G_SIZE + `B_SIZE)

// Pixels that never escape
`define IN_SET_COLOR 8'h00

`endif

//--- list.f
+incdir+include
source/render_pkg.sv
source/bus_pkg.sv
source/view_decode.sv
source/mandelbrot_iter.sv
source/pixel_writer.sv
source/framebuffer_mem.sv
source/mandelbrot_framebuffer.sv
dv/mandelbrot_framebuffer_assert.sv
dv/tb_mandelbrot_framebuffer.sv

//--- source/bus_pkg.sv
package bus_pkg;

    // ------------------------------------------------------------
    // Wishbone framebuffer bus
    // ------------------------------------------------------------

    localparam int wb_aw = 10;
    localparam int wb_dw = 8;

    // One word per pixel
    localparam int fb_depth = render_pkg::screen_w * render_pkg::screen_h;

    // Raster address of a pixel, rows of screen_w words
    function automatic logic [wb_aw-1:0] pixel_addr(
        input logic [render_pkg::x_w-1:0] x,
        input logic [render_pkg::y_w-1:0] y
    );
        return wb_aw'(y * render_pkg::screen_w + x);
    endfunction

endpackage

//--- source/framebuffer_mem.sv
module framebuffer_mem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [bus_pkg::wb_aw-1:0] wb_adr,
    input  logic [bus_pkg::wb_dw-1:0] wb_dat_w,
    input  logic [bus_pkg::wb_aw-1:0] rd_addr,
    output logic                      wb_ack,
    output logic [bus_pkg::wb_dw-1:0] rd_data
);

    logic [bus_pkg::wb_dw-1:0] mem [bus_pkg::fb_depth];
    logic                      req;

    // First cycle of a request, ack not yet given
    assign req = wb_cyc & wb_stb & ~wb_ack;

    // ------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------

    // Single-cycle registered ack
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Write lands on the edge that raises ack
    always_ff @(posedge clk) begin
        if (req && wb_we) begin
            mem[wb_adr] <= wb_dat_w;
        end
    end

    // ------------------------------------------------------------
    // Display side
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- source/mandelbrot_framebuffer.sv
module mandelbrot_framebuffer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           zoom_in,
    input  logic                           zoom_out,
    input  logic                           start_ovd,
    input  logic [render_pkg::coord_w-1:0] start_real_ovd,
    input  logic [render_pkg::coord_w-1:0] start_imag_ovd,
    input  logic [render_pkg::iter_w-1:0]  max_iteration,
    input  logic [bus_pkg::wb_aw-1:0]      rd_addr,
    output logic                           busy,
    output logic                           frame_done,
    output logic [render_pkg::zoom_w-1:0]  zoom_level,
    output logic [bus_pkg::wb_dw-1:0]      rd_data
);

    // ------------------------------------------------------------
    // Interconnect
    // ------------------------------------------------------------

    // Pixel coordinates into the engine
    logic                           pix_valid;
    logic                           pix_ready;
    logic [render_pkg::x_w-1:0]     pix_x;
    logic [render_pkg::y_w-1:0]     pix_y;
    logic [render_pkg::coord_w-1:0] c_re;
    logic [render_pkg::coord_w-1:0] c_im;

    // Escape counts out of the engine
    logic                           res_valid;
    logic                           res_ready;
    logic [render_pkg::x_w-1:0]     res_x;
    logic [render_pkg::y_w-1:0]     res_y;
    logic [render_pkg::iter_w-1:0]  res_count;

    // Wishbone
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [bus_pkg::wb_aw-1:0]      wb_adr;
    logic [bus_pkg::wb_dw-1:0]      wb_dat_w;
    logic                           wb_ack;

    // ------------------------------------------------------------
    // Render path and framebuffer
    // ------------------------------------------------------------

    view_decode u_view_decode (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .zoom_in        (zoom_in),
        .zoom_out       (zoom_out),
        .start_ovd      (start_ovd),
        .start_real_ovd (start_real_ovd),
        .start_imag_ovd (start_imag_ovd),
        .pix_ready      (pix_ready),
        .frame_done     (frame_done),
        .busy           (busy),
        .zoom_level     (zoom_level),
        .pix_valid      (pix_valid),
        .pix_x          (pix_x),
        .pix_y          (pix_y),
        .c_re           (c_re),
        .c_im           (c_im)
    );

    mandelbrot_iter u_mandelbrot_iter (
        .clk           (clk),
        .rst           (rst),
        .max_iteration (max_iteration),
        .pix_valid     (pix_valid),
        .pix_x         (pix_x),
        .pix_y         (pix_y),
        .c_re          (c_re),
        .c_im          (c_im),
        .res_ready     (res_ready),
        .pix_ready     (pix_ready),
        .res_valid     (res_valid),
        .res_x         (res_x),
        .res_y         (res_y),
        .res_count     (res_count)
    );

    pixel_writer u_pixel_writer (
        .clk           (clk),
        .rst           (rst),
        .max_iteration (max_iteration),
        .res_valid     (res_valid),
        .res_x         (res_x),
        .res_y         (res_y),
        .res_count     (res_count),
        .wb_ack        (wb_ack),
        .res_ready     (res_ready),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .frame_done    (frame_done)
    );

    framebuffer_mem u_framebuffer_mem (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .rd_addr  (rd_addr),
        .wb_ack   (wb_ack),
        .rd_data  (rd_data)
    );

endmodule

//--- source/mandelbrot_iter.sv
module mandelbrot_iter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [render_pkg::iter_w-1:0]  max_iteration,
    input  logic                           pix_valid,
    input  logic [render_pkg::x_w-1:0]     pix_x,
    input  logic [render_pkg::y_w-1:0]     pix_y,
    input  logic [render_pkg::coord_w-1:0] c_re,
    input  logic [render_pkg::coord_w-1:0] c_im,
    input  logic                           res_ready,
    output logic                           pix_ready,
    output logic                           res_valid,
    output logic [render_pkg::x_w-1:0]     res_x,
    output logic [render_pkg::y_w-1:0]     res_y,
    output logic [render_pkg::iter_w-1:0]  res_count
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t state;

    logic                                 pix_fire;
    logic                                 escaped;
    logic                                 limit_hit;
    logic signed [render_pkg::coord_w-1:0] z_re;
    logic signed [render_pkg::coord_w-1:0] z_im;
    logic signed [render_pkg::coord_w-1:0] cr;
    logic signed [render_pkg::coord_w-1:0] ci;
    logic signed [render_pkg::coord_w-1:0] z_re_next;
    logic signed [render_pkg::coord_w-1:0] z_im_next;
    logic signed [render_pkg::prod_w-1:0]  p_rr;
    logic signed [render_pkg::prod_w-1:0]  p_ii;
    logic signed [render_pkg::prod_w-1:0]  p_ri;
    logic        [render_pkg::prod_w-1:0]  mag;

    assign pix_ready = state == IDLE;
    assign res_valid = state == DONE;
    assign pix_fire  = pix_valid & pix_ready;

    // ------------------------------------------------------------
    // One step of z = z^2 + c
    // ------------------------------------------------------------

    assign p_rr = z_re * z_re;
    assign p_ii = z_im * z_im;
    assign p_ri = z_re * z_im;

    // Both squares are non-negative, so the sum fits unsigned
    assign mag       = $unsigned(p_rr) + $unsigned(p_ii);
    assign escaped   = mag > render_pkg::escape_limit;
    assign limit_hit = res_count == max_iteration;

    // Rescale each product back to Q4.28
    assign z_re_next = render_pkg::coord_w'((p_rr >>> render_pkg::frac_bits) -
                                            (p_ii >>> render_pkg::frac_bits)) + cr;
    assign z_im_next = render_pkg::coord_w'((p_ri >>> render_pkg::frac_bits) <<< 1) + ci;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (pix_fire) state <= RUN;
                RUN: if (escaped || limit_hit) state <= DONE;
                DONE: if (res_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pix_fire) begin
            cr        <= c_re;
            ci        <= c_im;
            z_re      <= '0;
            z_im      <= '0;
            res_count <= '0;
            res_x     <= pix_x;
            res_y     <= pix_y;
        end else if (state == RUN && !escaped && !limit_hit) begin
            z_re      <= z_re_next;
            z_im      <= z_im_next;
            res_count <= res_count + 1'b1;
        end
    end

endmodule

//--- source/pixel_writer.sv
`include "color.svh"

module pixel_writer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [render_pkg::iter_w-1:0] max_iteration,
    input  logic                          res_valid,
    input  logic [render_pkg::x_w-1:0]    res_x,
    input  logic [render_pkg::y_w-1:0]    res_y,
    input  logic [render_pkg::iter_w-1:0] res_count,
    input  logic                          wb_ack,
    output logic                          res_ready,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output logic [bus_pkg::wb_aw-1:0]     wb_adr,
    output logic [bus_pkg::wb_dw-1:0]     wb_dat_w,
    output logic                          frame_done
);

    logic                    res_fire;
    logic                    last_pixel;
    logic [`COLOR_W-1:0]     color;

    // New results only while the bus is idle
    assign res_ready = ~wb_cyc;
    assign res_fire  = res_valid & res_ready;

    // Write-only master
    assign wb_we = wb_cyc;

    // ------------------------------------------------------------
    // Escape count to RGB332
    // ------------------------------------------------------------

    always_comb begin
        if (res_count == max_iteration) begin
            color = `IN_SET_COLOR;
        end else if (res_count[`COLOR_W-1:0] == '0) begin
            // Keep escaped pixels distinct from the in-set colour
            color = `COLOR_W'(1);
        end else begin
            color = res_count[`COLOR_W-1:0];
        end
    end

    // ------------------------------------------------------------
    // Wishbone classic write cycle
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= wb_cyc & wb_ack & last_pixel;
            if (res_fire) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end else if (wb_ack) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
            end
        end
    end

    // Address and data held for the whole cycle
    always_ff @(posedge clk) begin
        if (res_fire) begin
            wb_adr     <= bus_pkg::pixel_addr(res_x, res_y);
            wb_dat_w   <= color;
            last_pixel <= res_x == render_pkg::x_w'(render_pkg::screen_w - 1) &&
                          res_y == render_pkg::y_w'(render_pkg::screen_h - 1);
        end
    end

endmodule

//--- source/render_pkg.sv
package render_pkg;

    // ------------------------------------------------------------
    // Fixed-point format
    // ------------------------------------------------------------

    // Signed Q4.28 coordinates
    localparam int coord_w   = 32;
    localparam int frac_bits = 28;

    // Full width of a coordinate product before rescaling
    localparam int prod_w = 2 * coord_w;

    // Iteration counter and limit
    localparam int iter_w = 16;

    // ------------------------------------------------------------
    // Screen geometry
    // ------------------------------------------------------------

    localparam int screen_w = 32;
    localparam int screen_h = 24;
    localparam int x_w      = 5;
    localparam int y_w      = 5;

    // ------------------------------------------------------------
    // View window
    // ------------------------------------------------------------

    localparam int zoom_w   = 4;
    localparam int zoom_max = 15;

    // 3/32 per pixel at zoom level 0
    localparam logic [coord_w-1:0] base_step = 32'h0180_0000;

    // Default centre at -0.5 + 0i
    localparam logic signed [coord_w-1:0] center_re = 32'shF800_0000;
    localparam logic signed [coord_w-1:0] center_im = 32'sh0000_0000;

    // 4.0 with 2*frac_bits fractional bits, compared against |z|^2
    localparam logic [prod_w-1:0] escape_limit = prod_w'(4) << (2 * frac_bits);

endpackage

//--- source/view_decode.sv
module view_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           zoom_in,
    input  logic                           zoom_out,
    input  logic                           start_ovd,
    input  logic [render_pkg::coord_w-1:0] start_real_ovd,
    input  logic [render_pkg::coord_w-1:0] start_imag_ovd,
    input  logic                           pix_ready,
    input  logic                           frame_done,
    output logic                           busy,
    output logic [render_pkg::zoom_w-1:0]  zoom_level,
    output logic                           pix_valid,
    output logic [render_pkg::x_w-1:0]     pix_x,
    output logic [render_pkg::y_w-1:0]     pix_y,
    output logic [render_pkg::coord_w-1:0] c_re,
    output logic [render_pkg::coord_w-1:0] c_im
);

    logic                           busy_q;
    logic                           frame_start;
    logic                           pix_fire;
    logic                           last_x;
    logic                           last_y;
    logic [render_pkg::coord_w-1:0] step;
    logic [render_pkg::coord_w-1:0] step_next;
    logic [render_pkg::coord_w-1:0] origin_re;
    logic [render_pkg::coord_w-1:0] origin_re_next;
    logic [render_pkg::coord_w-1:0] origin_im_next;

    // Busy drops in the same cycle as the frame_done pulse
    assign busy        = busy_q & ~frame_done;
    assign frame_start = start & ~busy;
    assign pix_fire    = pix_valid & pix_ready;
    assign last_x      = pix_x == render_pkg::x_w'(render_pkg::screen_w - 1);
    assign last_y      = pix_y == render_pkg::y_w'(render_pkg::screen_h - 1);

    // ------------------------------------------------------------
    // Window of the next frame
    // ------------------------------------------------------------

    assign step_next = render_pkg::base_step >> zoom_level;

    // Top-left corner, half a screen away from the centre
    assign origin_re_next = start_ovd ? start_real_ovd :
        render_pkg::center_re - render_pkg::coord_w'(step_next * (render_pkg::screen_w / 2));
    assign origin_im_next = start_ovd ? start_imag_ovd :
        render_pkg::center_im - render_pkg::coord_w'(step_next * (render_pkg::screen_h / 2));

    // Zoom only moves between frames
    always_ff @(posedge clk) begin
        if (rst) begin
            zoom_level <= '0;
        end else if (!busy) begin
            if (zoom_in && zoom_level != render_pkg::zoom_w'(render_pkg::zoom_max)) begin
                zoom_level <= zoom_level + 1'b1;
            end else if (zoom_out && zoom_level != '0) begin
                zoom_level <= zoom_level - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Frame control and raster counter
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q    <= 1'b0;
            pix_valid <= 1'b0;
            pix_x     <= '0;
            pix_y     <= '0;
        end else begin
            if (frame_start) begin
                busy_q <= 1'b1;
            end else if (frame_done) begin
                busy_q <= 1'b0;
            end
            if (frame_start) begin
                pix_valid <= 1'b1;
                pix_x     <= '0;
                pix_y     <= '0;
            end else if (pix_fire) begin
                pix_x <= last_x ? '0 : pix_x + 1'b1;
                if (last_x) begin
                    pix_y <= pix_y + 1'b1;
                end
                if (last_x && last_y) begin
                    pix_valid <= 1'b0;
                end
            end
        end
    end

    // c tracks origin + (x, y) * step by accumulation
    always_ff @(posedge clk) begin
        if (frame_start) begin
            step      <= step_next;
            origin_re <= origin_re_next;
            c_re      <= origin_re_next;
            c_im      <= origin_im_next;
        end else if (pix_fire) begin
            if (last_x) begin
                c_re <= origin_re;
                c_im <= c_im + step;
            end else begin
                c_re <= c_re + step;
            end
        end
    end

endmodule
